// File: verilog.f
rou_pkg.sv
rou_dispatch_queue.sv
rou_phys_regfile.sv
rou_operand_bypass.sv
rou_reorder_buffer.sv
rou_commit_ctrl.sv
rou_top.sv
rou_tb_sva.sv
rou_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f verilog.f --top-module rou_tb -o rou_sim

out=$(./obj_dir/rou_sim)
echo "$out"
echo "$out" | grep -q "TEST OK"

// File: rou_tb.sv
`default_nettype none
`timescale 1ns/1ns

module rou_tb
  import rou_pkg::*;
();

  localparam int QUEUE_DEPTH    = 4;
  localparam int ROB_DEPTH      = 8;
  localparam int RANDOM_UOPS    = 60;
  localparam int STORE_UOPS     = 4;
  localparam int FULL_UOPS      = QUEUE_DEPTH + ROB_DEPTH + 1;
  localparam int TOTAL_UOPS     = RANDOM_UOPS + STORE_UOPS + FULL_UOPS;
  localparam int TIMEOUT_CYCLES = 200 * TOTAL_UOPS;

  typedef struct {
    rob_tag_t tag;
    preg_t    prd;
    xlen_t    pc;
    xlen_t    pnpc;
    bit       mis;
    int       delay;
  } exu_job_t;

  typedef struct {
    xlen_t pc;
    areg_t rd;
    preg_t prd;
    logic  store;
    logic  flush;
    logic  trap;
  } commit_exp_t;

  logic      clock = 1'b0;
  logic      rst_n;
  logic      rename_valid;
  uop_t      rename_uop;
  logic      rename_ready;
  logic      dispatch_valid;
  dispatch_t dispatch;
  logic      exu_ready;
  wb_t       wb_alu;
  wb_t       wb_lsu;
  logic      sq_ready;
  commit_t   commit;

  uop_t        to_send [$];
  uop_t        queued [$];
  exu_job_t    jobs [$];
  commit_exp_t rob_order [$];
  xlen_t       reg_val [NUM_PREGS];
  logic        reg_rdy [NUM_PREGS];
  bit          mispredict_of [TOTAL_UOPS];
  logic [31:0] seed;
  int          uop_count;
  int          transfers;
  int          dispatches;
  int          commits;
  int          error_count;
  bit          random_mode;
  bit          hold_wb;
  rob_tag_t    exp_tag;

  rou_top #(
    .QUEUE_DEPTH (QUEUE_DEPTH),
    .ROB_DEPTH   (ROB_DEPTH)
  ) rou_top_i (
    .clock          (clock),
    .rst_n          (rst_n),
    .rename_valid   (rename_valid),
    .rename_uop     (rename_uop),
    .rename_ready   (rename_ready),
    .dispatch_valid (dispatch_valid),
    .dispatch       (dispatch),
    .exu_ready      (exu_ready),
    .wb_alu         (wb_alu),
    .wb_lsu         (wb_lsu),
    .sq_ready       (sq_ready),
    .commit         (commit)
  );

  always #4 clock = ~clock;

  // ====================
  // Helpers
  // ====================
  function automatic logic [31:0] next_rand();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed >> 8;
  endfunction

  function automatic xlen_t exp_result(input rob_tag_t tag, input xlen_t pc);
    return (pc << 4) ^ {28'h0, tag} ^ 32'h5a5a_0000;
  endfunction

  // Operand rule: imm, ready register, LSU bus, ALU bus, else unresolved
  function automatic logic [PREG_BITS+XLEN-1:0] ref_operand(input preg_t tag,
                                                            input xlen_t imm);
    if (tag == '0) return {preg_t'(0), imm};
    if (reg_rdy[tag]) return {preg_t'(0), reg_val[tag]};
    if (wb_lsu.valid && wb_lsu.prd == tag) return {preg_t'(0), wb_lsu.result};
    if (wb_alu.valid && wb_alu.prd == tag) return {preg_t'(0), wb_alu.result};
    return {tag, xlen_t'(0)};
  endfunction

  task automatic check(input string name, input logic [31:0] got,
                       input logic [31:0] exp);
    if (got !== exp) begin
      error_count++;
      $display("FAIL %s got %h expected %h", name, got, exp);
      $display("TEST FAILED");
      $fatal(1);
    end
  endtask

  task automatic fail_plain(input string msg);
    error_count++;
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  // Source picks a recent destination, or an immediate
  function automatic preg_t pick_src();
    logic [31:0] r;
    int          idx;
    r = next_rand();
    idx = uop_count - 1 - int'((r >> 4) % 6);
    if (r % 4 == 0 || idx < 0) return '0;
    return preg_t'(idx % 63 + 1);
  endfunction

  // sel < 0 picks a random kind
  task automatic make_uop(input int sel, input bit may_flush);
    uop_t        u;
    logic [31:0] r;
    r = next_rand() % 10;
    if (sel >= 0) u.kind = uop_kind_e'(sel);
    else if (r < 5) u.kind = UOP_ALU;
    else if (r == 5) u.kind = UOP_BRANCH;
    else if (r == 6) u.kind = UOP_LOAD;
    else if (r < 9) u.kind = UOP_STORE;
    else u.kind = may_flush ? UOP_TRAP : UOP_ALU;
    u.pc   = 32'h1000 + 32'(uop_count) * 4;
    u.pnpc = (u.kind == UOP_BRANCH) ? u.pc + 32'h40 : u.pc + 32'h4;
    u.rd   = areg_t'(next_rand());
    u.prd  = (u.kind == UOP_STORE) ? preg_t'(0) : preg_t'(uop_count % 63 + 1);
    u.pr1  = pick_src();
    u.pr2  = pick_src();
    u.imm1 = next_rand() ^ 32'h00c0_0000;
    u.imm2 = next_rand();
    mispredict_of[uop_count] = may_flush && u.kind == UOP_BRANCH && next_rand() % 3 == 0;
    uop_count++;
    to_send.push_back(u);
  endtask

  task automatic wait_drain();
    while (to_send.size() != 0 || queued.size() != 0 || rob_order.size() != 0) begin
      @(negedge clock);
    end
  endtask

  // ====================
  // Reference model and comparison
  // ====================
  always @(posedge clock) begin : compare
    uop_t                    u;
    logic [PREG_BITS+XLEN-1:0] s1;
    logic [PREG_BITS+XLEN-1:0] s2;
    commit_exp_t             e;
    exu_job_t                j;
    logic                    fire;
    if (rst_n) begin
      fire = dispatch_valid && exu_ready;
      if (fire) begin
        if (queued.size() == 0) fail_plain("Dispatch fired with no micro-op queued");
        u  = queued.pop_front();
        s1 = ref_operand(u.pr1, u.imm1);
        s2 = ref_operand(u.pr2, u.imm2);
        check("dispatch.kind", 32'(dispatch.kind), 32'(u.kind));
        check("dispatch.op1", dispatch.op1, s1[XLEN-1:0]);
        check("dispatch.pr1", 32'(dispatch.pr1), 32'(s1[PREG_BITS+XLEN-1:XLEN]));
        check("dispatch.op2", dispatch.op2, s2[XLEN-1:0]);
        check("dispatch.pr2", 32'(dispatch.pr2), 32'(s2[PREG_BITS+XLEN-1:XLEN]));
        check("dispatch.prd", 32'(dispatch.prd), 32'(u.prd));
        check("dispatch.dest", 32'(dispatch.dest), 32'(exp_tag));
        j.tag   = exp_tag;
        j.prd   = u.prd;
        j.pc    = u.pc;
        j.pnpc  = u.pnpc;
        j.mis   = mispredict_of[(u.pc - 32'h1000) >> 2];
        j.delay = 1 + int'(next_rand() % 8);
        jobs.push_back(j);
        e.pc    = u.pc;
        e.rd    = u.rd;
        e.prd   = u.prd;
        e.store = (u.kind == UOP_STORE);
        e.trap  = (u.kind == UOP_TRAP);
        e.flush = j.mis || e.trap;
        rob_order.push_back(e);
        exp_tag = (exp_tag == rob_tag_t'(ROB_DEPTH)) ? rob_tag_t'(1) : exp_tag + 1'b1;
        dispatches++;
      end
      if (rename_valid && rename_ready) begin
        queued.push_back(to_send.pop_front());
        transfers++;
      end
      if (commit.valid) begin
        if (rob_order.size() == 0) fail_plain("Commit with no micro-op in flight");
        if (commit.store && !sq_ready) fail_plain("Store committed while sq_ready was low");
        e = rob_order.pop_front();
        check("commit.pc", commit.pc, e.pc);
        check("commit.rd", 32'(commit.rd), 32'(e.rd));
        check("commit.prd", 32'(commit.prd), 32'(e.prd));
        check("commit.store", 32'(commit.store), 32'(e.store));
        check("commit.flush", 32'(commit.flush), 32'(e.flush));
        check("commit.trap", 32'(commit.trap), 32'(e.trap));
        commits++;
      end
      // Register model follows alloc, then write-back, then flush
      if (fire && u.prd != '0) reg_rdy[u.prd] = 1'b0;
      if (wb_alu.valid && wb_alu.prd != '0) begin
        reg_val[wb_alu.prd] = wb_alu.result;
        reg_rdy[wb_alu.prd] = 1'b1;
      end
      if (wb_lsu.valid && wb_lsu.prd != '0) begin
        reg_val[wb_lsu.prd] = wb_lsu.result;
        reg_rdy[wb_lsu.prd] = 1'b1;
      end
      if (commit.valid && commit.flush) begin
        foreach (reg_rdy[k]) reg_rdy[k] = 1'b1;
        queued.delete();
        jobs.delete();
        rob_order.delete();
        exp_tag = rob_tag_t'(1);
      end
    end
  end

  // ====================
  // Rename and execution units
  // ====================
  always @(negedge clock) begin : drive
    int       i;
    exu_job_t j;
    wb_t      w;
    if (rst_n) begin
      if (random_mode) begin
        exu_ready = (next_rand() % 4) != 0;
        sq_ready  = next_rand() % 2 == 0;
      end
      rename_valid = to_send.size() != 0;
      if (rename_valid) rename_uop = to_send[0];
      wb_alu = '0;
      wb_lsu = '0;
      foreach (jobs[k]) begin
        if (jobs[k].delay > 0) jobs[k].delay--;
      end
      // Two tries per cycle at a random due job gives out-of-order returns
      for (int n = 0; n < 2; n++) begin
        if (!hold_wb && jobs.size() != 0) begin
          i = int'(next_rand() % jobs.size());
          if (jobs[i].delay == 0) begin
            j        = jobs[i];
            w.valid  = 1'b1;
            w.dest   = j.tag;
            w.prd    = j.prd;
            w.result = exp_result(j.tag, j.pc);
            w.npc    = j.mis ? j.pnpc + 32'h8 : j.pnpc;
            w.trap   = 1'b0;
            if (next_rand() % 2 == 0 && !wb_lsu.valid) wb_lsu = w;
            else if (!wb_alu.valid) wb_alu = w;
            else wb_lsu = w;
            jobs.delete(i);
          end
        end
      end
    end
  end

  // ====================
  // Test sequence
  // ====================
  initial begin : main
    int c0;
    int c1;
    seed         = 32'h8d11c386;
    rst_n        = 1'b0;
    rename_valid = 1'b0;
    rename_uop   = '0;
    exu_ready    = 1'b1;
    wb_alu       = '0;
    wb_lsu       = '0;
    sq_ready     = 1'b1;
    random_mode  = 1'b0;
    hold_wb      = 1'b0;
    exp_tag      = rob_tag_t'(1);
    foreach (reg_val[k]) begin
      reg_val[k] = '0;
      reg_rdy[k] = 1'b1;
    end
    repeat (4) @(posedge clock);
    @(negedge clock);
    rst_n = 1'b1;
    @(negedge clock);
    check("rename_ready", 32'(rename_ready), 32'd1);
    check("dispatch_valid", 32'(dispatch_valid), 32'd0);
    check("commit.valid", 32'(commit.valid), 32'd0);
    check("commit.store", 32'(commit.store), 32'd0);
    check("commit.flush", 32'(commit.flush), 32'd0);
    check("commit.trap", 32'(commit.trap), 32'd0);

    // Random traffic with mispredicts, traps and stores
    random_mode = 1'b1;
    repeat (RANDOM_UOPS) make_uop(-1, 1'b1);
    wait_drain();
    random_mode = 1'b0;
    @(negedge clock);
    exu_ready = 1'b1;
    sq_ready  = 1'b1;

    // Store stuck at the head holds back younger entries
    sq_ready = 1'b0;
    c0 = commits;
    make_uop(int'(UOP_STORE), 1'b0);
    repeat (STORE_UOPS - 1) make_uop(int'(UOP_ALU), 1'b0);
    repeat (40) @(negedge clock);
    check("commits while store blocked", 32'(commits - c0), 32'd0);
    check("entries in flight", 32'(rob_order.size()), 32'(STORE_UOPS));
    sq_ready = 1'b1;
    wait_drain();

    // Queue full, then ROB full
    @(negedge clock);
    exu_ready = 1'b0;
    c0 = transfers;
    c1 = dispatches;
    repeat (FULL_UOPS) make_uop(int'(UOP_ALU), 1'b0);
    repeat (10) @(negedge clock);
    check("queue transfers", 32'(transfers - c0), 32'(QUEUE_DEPTH));
    check("rename_ready", 32'(rename_ready), 32'd0);
    hold_wb   = 1'b1;
    exu_ready = 1'b1;
    repeat (20) @(negedge clock);
    check("dispatches into ROB", 32'(dispatches - c1), 32'(ROB_DEPTH));
    check("dispatch_valid", 32'(dispatch_valid), 32'd0);
    hold_wb = 1'b0;
    wait_drain();

    repeat (2) @(negedge clock);
    if (error_count == 0) begin
      $display("TEST OK");
      $finish;
    end else begin
      $display("TEST FAILED");
      $fatal(1);
    end
  end

  initial begin : watchdog
    repeat (TIMEOUT_CYCLES) @(posedge clock);
    $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("TEST FAILED");
    $fatal(1);
  end

endmodule

`default_nettype wire

// File: rou_tb_sva.sv
`default_nettype none
`timescale 1ns/1ns

module rou_commit_sva
  import rou_pkg::*;
(
  input wire logic        clock,
  input wire logic        rst_n,
  input wire logic        sq_ready,
  input wire logic        head_busy,
  input wire rob_state_e  head_state,
  input wire uop_kind_e   head_kind,
  input wire logic        retire,
  input wire logic [31:0] retire_count
);

  // Only a written-back entry can leave the head
  retire_needs_wb: assert property (@(posedge clock) disable iff (!rst_n)
    retire |-> (head_busy && head_state == ROB_WB))
    else $error("retire without a written-back head entry");

  // Store queue back-pressure
  store_needs_sq: assert property (@(posedge clock) disable iff (!rst_n)
    (retire && head_kind == UOP_STORE) |-> sq_ready)
    else $error("store retired while sq_ready was low");

  no_retire_in_reset: assert property (@(posedge clock)
    !rst_n |-> !retire)
    else $error("retire while reset is asserted");

  // Bookkeeping count moves by one per retired entry
  count_follows_retire: assert property (@(posedge clock) disable iff (!rst_n)
    retire |=> retire_count == $past(retire_count) + 32'd1)
    else $error("retire_count did not advance on retire");

endmodule

bind rou_commit_ctrl rou_commit_sva commit_sva_i (
  .clock        (clock),
  .rst_n        (rst_n),
  .sq_ready     (sq_ready),
  .head_busy    (head_busy),
  .head_state   (head_state),
  .head_kind    (head_kind),
  .retire       (retire),
  .retire_count (retire_count)
);

`default_nettype wire

// File: rou_top.sv
`default_nettype none
`timescale 1ns/1ns

module rou_top
  import rou_pkg::*;
#(
  parameter int QUEUE_DEPTH = 4,
  // At most 15 so tags fit in four bits
  parameter int ROB_DEPTH   = 8
) (
  input  logic      clock,
  input  logic      rst_n,
  input  logic      rename_valid,
  input  uop_t      rename_uop,
  output logic      rename_ready,
  output logic      dispatch_valid,
  output dispatch_t dispatch,
  input  logic      exu_ready,
  input  wb_t       wb_alu,
  input  wb_t       wb_lsu,
  input  logic      sq_ready,
  output commit_t   commit
);

  uop_t       head_uop;
  logic       head_valid;
  logic       deq;
  logic       flush;
  logic       retire;
  xlen_t      val1;
  xlen_t      val2;
  logic       rdy1;
  logic       rdy2;
  rob_tag_t   tail_tag;
  logic       rob_free;
  logic       rob_head_busy;
  rob_state_e rob_head_state;
  uop_kind_e  rob_head_kind;
  xlen_t      rob_head_pc;
  xlen_t      rob_head_npc;
  xlen_t      rob_head_pnpc;
  areg_t      rob_head_rd;
  preg_t      rob_head_prd;
  logic       rob_head_trap;

  // Dispatch needs a queued uop and a free ROB tail slot
  assign dispatch_valid = head_valid && rob_free;
  assign deq            = dispatch_valid && exu_ready;

  rou_dispatch_queue #(
    .DEPTH (QUEUE_DEPTH)
  ) queue_i (
    .clock      (clock),
    .rst_n      (rst_n),
    .flush      (flush),
    .in_valid   (rename_valid),
    .in_uop     (rename_uop),
    .in_ready   (rename_ready),
    .deq        (deq),
    .head_valid (head_valid),
    .head_uop   (head_uop)
  );

  rou_phys_regfile regfile_i (
    .clock     (clock),
    .rst_n     (rst_n),
    .flush     (flush),
    .rd1       (head_uop.pr1),
    .rd2       (head_uop.pr2),
    .val1      (val1),
    .val2      (val2),
    .rdy1      (rdy1),
    .rdy2      (rdy2),
    .alloc     (deq),
    .alloc_prd (head_uop.prd),
    .wb_alu    (wb_alu),
    .wb_lsu    (wb_lsu)
  );

  rou_operand_bypass bypass_i (
    .uop          (head_uop),
    .val1         (val1),
    .val2         (val2),
    .rdy1         (rdy1),
    .rdy2         (rdy2),
    .wb_alu       (wb_alu),
    .wb_lsu       (wb_lsu),
    .rob_tail_tag (tail_tag),
    .dispatch     (dispatch)
  );

  rou_reorder_buffer #(
    .DEPTH (ROB_DEPTH)
  ) rob_i (
    .clock      (clock),
    .rst_n      (rst_n),
    .flush      (flush),
    .insert     (deq),
    .insert_uop (head_uop),
    .tail_tag   (tail_tag),
    .rob_free   (rob_free),
    .wb_alu     (wb_alu),
    .wb_lsu     (wb_lsu),
    .retire     (retire),
    .head_busy  (rob_head_busy),
    .head_state (rob_head_state),
    .head_kind  (rob_head_kind),
    .head_pc    (rob_head_pc),
    .head_npc   (rob_head_npc),
    .head_pnpc  (rob_head_pnpc),
    .head_rd    (rob_head_rd),
    .head_prd   (rob_head_prd),
    .head_trap  (rob_head_trap)
  );

  rou_commit_ctrl commit_i (
    .clock      (clock),
    .rst_n      (rst_n),
    .sq_ready   (sq_ready),
    .head_busy  (rob_head_busy),
    .head_state (rob_head_state),
    .head_kind  (rob_head_kind),
    .head_pc    (rob_head_pc),
    .head_npc   (rob_head_npc),
    .head_pnpc  (rob_head_pnpc),
    .head_rd    (rob_head_rd),
    .head_prd   (rob_head_prd),
    .head_trap  (rob_head_trap),
    .retire     (retire),
    .flush      (flush),
    .commit     (commit)
  );

endmodule

`default_nettype wire

// File: rou_commit_ctrl.sv
`default_nettype none
`timescale 1ns/1ns

module rou_commit_ctrl
  import rou_pkg::*;
(
  input  logic       clock,
  input  logic       rst_n,
  input  logic       sq_ready,
  input  logic       head_busy,
  input  rob_state_e head_state,
  input  uop_kind_e  head_kind,
  input  xlen_t      head_pc,
  input  xlen_t      head_npc,
  input  xlen_t      head_pnpc,
  input  areg_t      head_rd,
  input  preg_t      head_prd,
  input  logic       head_trap,
  output logic       retire,
  output logic       flush,
  output commit_t    commit
);

  logic        head_store;
  logic        mispredict;
  logic [31:0] retire_count;

  assign head_store = (head_kind == UOP_STORE);
  assign mispredict = (head_npc != head_pnpc);

  // ====================
  // Retire and flush
  // ====================
  // A store also needs the store queue to take it
  assign retire = head_busy
                  && head_state == ROB_WB
                  && (!head_store || sq_ready);

  assign flush = retire && (mispredict || head_trap);

  always_comb begin
    commit.valid = retire;
    commit.pc    = head_pc;
    commit.rd    = head_rd;
    commit.prd   = head_prd;
    commit.store = retire && head_store;
    commit.flush = flush;
    commit.trap  = retire && head_trap;
  end

  // Running total of retired entries, read by bound checkers
  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      retire_count <= '0;
    end else if (retire) begin
      retire_count <= retire_count + 32'd1;
    end
  end

endmodule

`default_nettype wire

// File: rou_reorder_buffer.sv
`default_nettype none
`timescale 1ns/1ns

module rou_reorder_buffer
  import rou_pkg::*;
#(
  parameter int DEPTH = 8
) (
  input  logic       clock,
  input  logic       rst_n,
  input  logic       flush,
  input  logic       insert,
  input  uop_t       insert_uop,
  output rob_tag_t   tail_tag,
  output logic       rob_free,
  input  wb_t        wb_alu,
  input  wb_t        wb_lsu,
  input  logic       retire,
  output logic       head_busy,
  output rob_state_e head_state,
  output uop_kind_e  head_kind,
  output xlen_t      head_pc,
  output xlen_t      head_npc,
  output xlen_t      head_pnpc,
  output areg_t      head_rd,
  output preg_t      head_prd,
  output logic       head_trap
);

  localparam int IW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  typedef logic [IW-1:0] idx_t;

  typedef struct packed {
    uop_kind_e kind;
    xlen_t     pc;
    xlen_t     pnpc;
    xlen_t     npc;
    areg_t     rd;
    preg_t     prd;
    logic      trap;
  } rob_entry_t;

  rob_entry_t       entries [DEPTH];
  rob_state_e       state   [DEPTH];
  logic [DEPTH-1:0] busy;
  idx_t             head;
  idx_t             tail;
  idx_t             alu_idx;
  idx_t             lsu_idx;
  logic             alu_hit;
  logic             lsu_hit;

  function automatic idx_t next_idx(input idx_t i);
    return (i == idx_t'(DEPTH - 1)) ? '0 : i + 1'b1;
  endfunction

  // Tags are slot + 1, zero never names an entry
  assign alu_idx = idx_t'(wb_alu.dest - 1'b1);
  assign lsu_idx = idx_t'(wb_lsu.dest - 1'b1);
  assign alu_hit = wb_alu.valid && wb_alu.dest != '0
                   && wb_alu.dest <= rob_tag_t'(DEPTH) && busy[alu_idx];
  assign lsu_hit = wb_lsu.valid && wb_lsu.dest != '0
                   && wb_lsu.dest <= rob_tag_t'(DEPTH) && busy[lsu_idx];

  assign tail_tag = rob_tag_t'(tail) + rob_tag_t'(1);
  assign rob_free = !busy[tail];

  // ====================
  // Control state
  // ====================
  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      head <= '0;
      tail <= '0;
      busy <= '0;
      for (int i = 0; i < DEPTH; i++) begin
        state[i] <= ROB_CM;
      end
    end else if (flush) begin
      head <= '0;
      tail <= '0;
      busy <= '0;
      for (int i = 0; i < DEPTH; i++) begin
        state[i] <= ROB_CM;
      end
    end else begin
      if (insert) begin
        busy[tail]  <= 1'b1;
        state[tail] <= ROB_EX;
        tail        <= next_idx(tail);
      end
      if (alu_hit) begin
        state[alu_idx] <= ROB_WB;
      end
      if (lsu_hit) begin
        state[lsu_idx] <= ROB_WB;
      end
      if (retire) begin
        busy[head]  <= 1'b0;
        state[head] <= ROB_CM;
        head        <= next_idx(head);
      end
    end
  end

  // ====================
  // Entry payload
  // ====================
  always_ff @(posedge clock) begin
    if (insert) begin
      entries[tail].kind <= insert_uop.kind;
      entries[tail].pc   <= insert_uop.pc;
      entries[tail].pnpc <= insert_uop.pnpc;
      entries[tail].npc  <= insert_uop.pnpc;
      entries[tail].rd   <= insert_uop.rd;
      entries[tail].prd  <= insert_uop.prd;
      entries[tail].trap <= (insert_uop.kind == UOP_TRAP);
    end
    // A trap uop keeps its trap whatever the unit reports
    if (alu_hit) begin
      entries[alu_idx].npc  <= wb_alu.npc;
      entries[alu_idx].trap <= wb_alu.trap || (entries[alu_idx].kind == UOP_TRAP);
    end
    if (lsu_hit) begin
      entries[lsu_idx].npc  <= wb_lsu.npc;
      entries[lsu_idx].trap <= wb_lsu.trap || (entries[lsu_idx].kind == UOP_TRAP);
    end
  end

  assign head_busy  = busy[head];
  assign head_state = state[head];
  assign head_kind  = entries[head].kind;
  assign head_pc    = entries[head].pc;
  assign head_npc   = entries[head].npc;
  assign head_pnpc  = entries[head].pnpc;
  assign head_rd    = entries[head].rd;
  assign head_prd   = entries[head].prd;
  assign head_trap  = entries[head].trap;

endmodule

`default_nettype wire

// File: rou_operand_bypass.sv
`default_nettype none
`timescale 1ns/1ns

module rou_operand_bypass
  import rou_pkg::*;
(
  input  uop_t      uop,
  input  xlen_t     val1,
  input  xlen_t     val2,
  input  logic      rdy1,
  input  logic      rdy2,
  input  wb_t       wb_alu,
  input  wb_t       wb_lsu,
  input  rob_tag_t  rob_tail_tag,
  output dispatch_t dispatch
);

  // One resolved source: leftover tag and value
  typedef struct packed {
    preg_t tag;
    xlen_t value;
  } operand_t;

  operand_t src1;
  operand_t src2;

  // Priority is register file, then LSU bus, then ALU bus
  function automatic operand_t resolve(
    input preg_t tag,
    input xlen_t imm,
    input xlen_t rf_val,
    input logic  rf_rdy,
    input wb_t   lsu_bus,
    input wb_t   alu_bus
  );
    operand_t res;
    res.tag = '0;
    if (tag == '0) begin
      res.value = imm;
    end else if (rf_rdy) begin
      res.value = rf_val;
    end else if (lsu_bus.valid && lsu_bus.prd == tag) begin
      res.value = lsu_bus.result;
    end else if (alu_bus.valid && alu_bus.prd == tag) begin
      res.value = alu_bus.result;
    end else begin
      // Still waiting on a producer
      res.tag   = tag;
      res.value = '0;
    end
    return res;
  endfunction

  assign src1 = resolve(uop.pr1, uop.imm1, val1, rdy1, wb_lsu, wb_alu);
  assign src2 = resolve(uop.pr2, uop.imm2, val2, rdy2, wb_lsu, wb_alu);

  always_comb begin
    dispatch.kind = uop.kind;
    dispatch.op1  = src1.value;
    dispatch.op2  = src2.value;
    dispatch.pr1  = src1.tag;
    dispatch.pr2  = src2.tag;
    dispatch.prd  = uop.prd;
    dispatch.dest = rob_tail_tag;
  end

endmodule

`default_nettype wire

// File: rou_phys_regfile.sv
`default_nettype none
`timescale 1ns/1ns

module rou_phys_regfile
  import rou_pkg::*;
(
  input  logic  clock,
  input  logic  rst_n,
  input  logic  flush,
  input  preg_t rd1,
  input  preg_t rd2,
  output xlen_t val1,
  output xlen_t val2,
  output logic  rdy1,
  output logic  rdy2,
  input  logic  alloc,
  input  preg_t alloc_prd,
  input  wb_t   wb_alu,
  input  wb_t   wb_lsu
);

  xlen_t                regs [NUM_PREGS];
  logic [NUM_PREGS-1:0] ready;

  // Register 0 is never written and never allocated, so it stays 0 and ready
  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      ready <= '1;
      for (int i = 0; i < NUM_PREGS; i++) begin
        regs[i] <= '0;
      end
    end else begin
      if (alloc && alloc_prd != '0) begin
        ready[alloc_prd] <= 1'b0;
      end
      if (wb_alu.valid && wb_alu.prd != '0) begin
        regs[wb_alu.prd]  <= wb_alu.result;
        ready[wb_alu.prd] <= 1'b1;
      end
      if (wb_lsu.valid && wb_lsu.prd != '0) begin
        regs[wb_lsu.prd]  <= wb_lsu.result;
        ready[wb_lsu.prd] <= 1'b1;
      end
      // Flush drops every pending producer, values stay
      if (flush) begin
        ready <= '1;
      end
    end
  end

  assign val1 = regs[rd1];
  assign val2 = regs[rd2];
  assign rdy1 = ready[rd1];
  assign rdy2 = ready[rd2];

endmodule

`default_nettype wire

// File: rou_dispatch_queue.sv
`default_nettype none
`timescale 1ns/1ns

module rou_dispatch_queue
  import rou_pkg::*;
#(
  parameter int DEPTH = 4
) (
  input  logic clock,
  input  logic rst_n,
  input  logic flush,
  input  logic in_valid,
  input  uop_t in_uop,
  output logic in_ready,
  input  logic deq,
  output logic head_valid,
  output uop_t head_uop
);

  localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  typedef logic [PW-1:0] ptr_t;

  uop_t             slots [DEPTH];
  logic [DEPTH-1:0] slot_valid;
  ptr_t             wr_ptr;
  ptr_t             rd_ptr;
  logic             enq;
  logic             pop;

  // Wrap explicitly so depths that are not a power of two work
  function automatic ptr_t next_ptr(input ptr_t p);
    return (p == ptr_t'(DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  // Accept only while the write slot is empty
  assign in_ready   = !slot_valid[wr_ptr];
  assign enq        = in_valid && in_ready;
  assign head_valid = slot_valid[rd_ptr];
  assign head_uop   = slots[rd_ptr];
  assign pop        = deq && head_valid;

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      slot_valid <= '0;
    end else if (flush) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      slot_valid <= '0;
    end else begin
      if (enq) begin
        slot_valid[wr_ptr] <= 1'b1;
        wr_ptr             <= next_ptr(wr_ptr);
      end
      if (pop) begin
        slot_valid[rd_ptr] <= 1'b0;
        rd_ptr             <= next_ptr(rd_ptr);
      end
    end
  end

  // Payload storage
  always_ff @(posedge clock) begin
    if (enq) begin
      slots[wr_ptr] <= in_uop;
    end
  end

endmodule

`default_nettype wire

// File: rou_pkg.sv
`default_nettype none

package rou_pkg;

  // ====================
  // Widths
  // ====================
  localparam int XLEN      = 32;
  localparam int PREG_BITS = 6;
  localparam int NUM_PREGS = 64;
  localparam int TAG_BITS  = 4;
  localparam int AREG_BITS = 5;

  typedef logic [XLEN-1:0]      xlen_t;
  typedef logic [PREG_BITS-1:0] preg_t;
  typedef logic [TAG_BITS-1:0]  rob_tag_t;
  typedef logic [AREG_BITS-1:0] areg_t;

  // ====================
  // Enums
  // ====================
  typedef enum logic [2:0] {
    UOP_ALU    = 3'd0,
    UOP_BRANCH = 3'd1,
    UOP_LOAD   = 3'd2,
    UOP_STORE  = 3'd3,
    UOP_TRAP   = 3'd4
  } uop_kind_e;

  typedef enum logic [1:0] {
    ROB_EX = 2'd0,
    ROB_WB = 2'd1,
    ROB_CM = 2'd2
  } rob_state_e;

  // ====================
  // Structs
  // ====================
  // Renamed micro-op as delivered by rename
  typedef struct packed {
    uop_kind_e kind;
    xlen_t     pc;
    xlen_t     pnpc;
    areg_t     rd;
    preg_t     pr1;
    preg_t     pr2;
    preg_t     prd;
    xlen_t     imm1;
    xlen_t     imm2;
  } uop_t;

  // Packet to execution; pr1/pr2 are zero once resolved
  typedef struct packed {
    uop_kind_e kind;
    xlen_t     op1;
    xlen_t     op2;
    preg_t     pr1;
    preg_t     pr2;
    preg_t     prd;
    rob_tag_t  dest;
  } dispatch_t;

  typedef struct packed {
    logic     valid;
    rob_tag_t dest;
    preg_t    prd;
    xlen_t    result;
    xlen_t    npc;
    logic     trap;
  } wb_t;

  typedef struct packed {
    logic  valid;
    xlen_t pc;
    areg_t rd;
    preg_t prd;
    logic  store;
    logic  flush;
    logic  trap;
  } commit_t;

endpackage

`default_nettype wire
